// File: hw/lc3_config.svh
/* Word width, memory address width, queue depth and reset PC */
`ifndef LC3_CONFIG_SVH
`define LC3_CONFIG_SVH

`define LC3_WORD_WIDTH 16
`define LC3_ADDR_WIDTH 20

// Entries in the instruction queue
`define LC3_QUEUE_DEPTH 4

// Start of user program space
`define LC3_RESET_PC 16'h3000

`endif

// File: hw/lc3IsaPkg.sv
/* Instruction-set types: opcode enumeration and decoded instruction */
`include "lc3_config.svh"

package lc3IsaPkg;

	typedef enum logic [3:0]
	{
		opBr   = 4'b0000,
		opAdd  = 4'b0001,
		opLd   = 4'b0010,
		opSt   = 4'b0011,
		opJsr  = 4'b0100,
		opAnd  = 4'b0101,
		opLdr  = 4'b0110,
		opStr  = 4'b0111,
		opRti  = 4'b1000,
		opNot  = 4'b1001,
		opLdi  = 4'b1010,
		opSti  = 4'b1011,
		opJmp  = 4'b1100,
		opRes  = 4'b1101,
		opLea  = 4'b1110,
		opTrap = 4'b1111
	} opcodeT;

	typedef struct packed
	{
		logic [`LC3_WORD_WIDTH-1:0] pc;
		opcodeT                     opcode;
		logic [2:0]                 dr;
		logic [2:0]                 sr1;
		logic [`LC3_WORD_WIDTH-1:0] imm;
		// pc+1 plus offset, BR and JSR only
		logic [`LC3_WORD_WIDTH-1:0] target;
		logic                       redirect;
	} decodedT;

endpackage

// File: hw/fetchBusPkg.sv
/* Transport structs for memory requests, queue entries and redirects */
`include "lc3_config.svh"

package fetchBusPkg;

	typedef struct packed
	{
		logic [`LC3_ADDR_WIDTH-1:0] addr;
	} memReqT;

	typedef struct packed
	{
		logic [`LC3_WORD_WIDTH-1:0] pc;
		logic [`LC3_WORD_WIDTH-1:0] instr;
	} queueEntryT;

	// Valid for a single cycle
	typedef struct packed
	{
		logic                       valid;
		logic [`LC3_WORD_WIDTH-1:0] target;
	} redirectT;

endpackage

// File: hw/fetchUnit.sv
/* Fetch unit: PC, MAR, MDR and IR load registers, PC select, address
   zero extension and the FSM for memory and push handshakes */
`timescale 1ns/100ps
`include "lc3_config.svh"

module fetchUnit
(
	input  logic                       Clk,
	input  logic                       reset,
	output fetchBusPkg::memReqT        memReq,
	output logic                       memReqValid,
	input  logic                       memAck,
	input  logic [`LC3_WORD_WIDTH-1:0] memData,
	output logic                       pushReq,
	output fetchBusPkg::queueEntryT    pushEntry,
	input  logic                       pushAck,
	input  fetchBusPkg::redirectT      redirect
);

	typedef enum logic [2:0]
	{
		stateMar,
		stateMemReq,
		stateMemDone,
		statePushReq,
		statePushDone
	} stateT;

	stateT                      state;
	logic [`LC3_WORD_WIDTH-1:0] pcReg;
	logic [`LC3_WORD_WIDTH-1:0] pcNext;
	logic [`LC3_WORD_WIDTH-1:0] marReg;
	logic [`LC3_WORD_WIDTH-1:0] mdrReg;
	logic [`LC3_WORD_WIDTH-1:0] irReg;
	logic                       stale;
	logic                       ldPc;
	logic                       ldMar;
	logic                       ldMdr;
	logic                       ldIr;

	// MAR waits a cycle on redirect so it picks up the new PC
	assign ldMar = (state == stateMar) && !redirect.valid;
	assign ldMdr = (state == stateMemReq) && memAck;
	assign ldIr  = (state == stateMemDone) && !memAck;
	assign ldPc  = redirect.valid || ((state == statePushReq) && pushAck && !stale);

	// PC select with redirect target over increment
	always_comb
	begin
		if (redirect.valid)
			pcNext = redirect.target;
		else
			pcNext = pcReg + 1'b1;
	end

	always_ff @(posedge Clk)
	begin
		if (reset)
			pcReg <= `LC3_RESET_PC;
		else if (ldPc)
			pcReg <= pcNext;
	end

	always_ff @(posedge Clk)
	begin
		if (ldMar)
			marReg <= pcReg;
		if (ldMdr)
			mdrReg <= memData;
		if (ldIr)
			irReg <= mdrReg;
	end

	// Zero extend MAR onto the memory address
	assign memReq.addr     = {{(`LC3_ADDR_WIDTH - `LC3_WORD_WIDTH){1'b0}}, marReg};
	assign pushEntry.pc    = marReg;
	assign pushEntry.instr = irReg;

	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			state       <= stateMar;
			memReqValid <= 1'b0;
			pushReq     <= 1'b0;
			stale       <= 1'b0;
		end
		else
		begin
			case (state)
				stateMar:
				begin
					if (!redirect.valid)
					begin
						memReqValid <= 1'b1;
						state       <= stateMemReq;
					end
				end
				stateMemReq:
				begin
					if (redirect.valid)
						stale <= 1'b1;
					if (memAck)
					begin
						memReqValid <= 1'b0;
						state       <= stateMemDone;
					end
				end
				stateMemDone:
				begin
					// Wrong-path word is dropped here, never pushed
					if (!memAck && (stale || redirect.valid))
					begin
						stale <= 1'b0;
						state <= stateMar;
					end
					else if (!memAck)
					begin
						pushReq <= 1'b1;
						state   <= statePushReq;
					end
					else if (redirect.valid)
						stale <= 1'b1;
				end
				statePushReq:
				begin
					if (pushAck)
					begin
						pushReq <= 1'b0;
						stale   <= 1'b0;
						state   <= statePushDone;
					end
					else if (redirect.valid)
						stale <= 1'b1;
				end
				statePushDone:
				begin
					if (!pushAck)
						state <= stateMar;
				end
				default:
					state <= stateMar;
			endcase
		end
	end

	memReqStable: assert property (@(posedge Clk) disable iff (reset)
		memReqValid |=> !memReqValid || $stable(memReq));

	pushReqHeld: assert property (@(posedge Clk) disable iff (reset)
		pushReq && !pushAck |=> pushReq && $stable(pushEntry));

endmodule

// File: hw/instrQueue.sv
/* Circular instruction queue with four-phase push and pop sides
   and flush on redirect */
`timescale 1ns/100ps
`include "lc3_config.svh"

module instrQueue
(
	input  logic                    Clk,
	input  logic                    reset,
	input  logic                    pushReq,
	input  fetchBusPkg::queueEntryT pushEntry,
	output logic                    pushAck,
	output logic                    popReq,
	output fetchBusPkg::queueEntryT popEntry,
	input  logic                    popAck,
	input  fetchBusPkg::redirectT   redirect
);

	localparam int Depth    = `LC3_QUEUE_DEPTH;
	localparam int PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
	localparam int CntWidth = $clog2(Depth + 1);

	fetchBusPkg::queueEntryT entries [Depth];
	logic [PtrWidth-1:0]     rdPtr;
	logic [PtrWidth-1:0]     wrPtr;
	logic [PtrWidth-1:0]     rdPtrNext;
	logic [PtrWidth-1:0]     wrPtrNext;
	logic [CntWidth-1:0]     count;
	logic                    acceptPush;
	logic                    writeEn;
	logic                    popDone;
	logic                    pushStale;

	assign acceptPush = pushReq && !pushAck && (count != CntWidth'(Depth));
	// A push left open across a redirect holds a wrong-path instruction
	assign writeEn    = acceptPush && !redirect.valid && !pushStale;
	assign popDone    = popReq && popAck;
	assign rdPtrNext  = (rdPtr == PtrWidth'(Depth - 1)) ? '0 : rdPtr + 1'b1;
	assign wrPtrNext  = (wrPtr == PtrWidth'(Depth - 1)) ? '0 : wrPtr + 1'b1;
	assign popEntry   = entries[rdPtr];

	always_ff @(posedge Clk)
	begin
		if (writeEn)
			entries[wrPtr] <= pushEntry;
	end

	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			rdPtr     <= '0;
			wrPtr     <= '0;
			count     <= '0;
			pushAck   <= 1'b0;
			popReq    <= 1'b0;
			pushStale <= 1'b0;
		end
		else
		begin
			if (acceptPush)
				pushAck <= 1'b1;
			else if (pushAck && !pushReq)
				pushAck <= 1'b0;
			if (redirect.valid && pushReq && !pushAck && !acceptPush)
				pushStale <= 1'b1;
			else if (acceptPush)
				pushStale <= 1'b0;

			if (popDone)
				popReq <= 1'b0;
			else if (!popReq && !popAck && count != '0)
				popReq <= 1'b1;

			if (redirect.valid)
			begin
				// Flush all but the head under acknowledgement
				rdPtr <= popDone ? rdPtrNext : rdPtr;
				wrPtr <= (count != '0) ? rdPtrNext : rdPtr;
				count <= (count != '0 && !popDone) ? CntWidth'(1) : '0;
			end
			else
			begin
				if (writeEn)
					wrPtr <= wrPtrNext;
				if (popDone)
					rdPtr <= rdPtrNext;
				count <= count + CntWidth'(writeEn) - CntWidth'(popDone);
			end
		end
	end

	// Full means both pointers meet with entries held
	noPushWhenFull: assert property (@(posedge Clk) disable iff (reset)
		$rose(pushAck) |-> $past(wrPtr != rdPtr || count == '0));

	popEntryStable: assert property (@(posedge Clk) disable iff (reset)
		popReq |=> !popReq || $stable(popEntry));

endmodule

// File: hw/instrDecoder.sv
/* Instruction decoder: field extraction, branch target, redirect
   and the four-phase output register */
`timescale 1ns/100ps
`include "lc3_config.svh"

module instrDecoder
(
	input  logic                    Clk,
	input  logic                    reset,
	input  logic                    popReq,
	input  fetchBusPkg::queueEntryT popEntry,
	output logic                    popAck,
	output fetchBusPkg::redirectT   redirect,
	output logic                    outReq,
	output lc3IsaPkg::decodedT      outInstr,
	input  logic                    outAck
);

	localparam int WordWidth = `LC3_WORD_WIDTH;

	typedef enum logic [1:0] {outIdle, outLoaded, outOpen, outClosing} outStateT;

	outStateT             outState;
	lc3IsaPkg::decodedT   decoded;
	logic [WordWidth-1:0] instr;
	logic                 capture;

	assign instr   = popEntry.instr;
	// Output register free and previous pop closed
	assign capture = (outState == outIdle) && popReq && !popAck;

	always_comb
	begin
		decoded        = '0;
		decoded.pc     = popEntry.pc;
		decoded.opcode = lc3IsaPkg::opcodeT'(instr[15:12]);
		decoded.dr     = instr[11:9];
		decoded.sr1    = instr[8:6];
		case (decoded.opcode)
			lc3IsaPkg::opAdd, lc3IsaPkg::opAnd:
				decoded.imm = {{(WordWidth - 5){instr[4]}}, instr[4:0]};
			lc3IsaPkg::opLdr, lc3IsaPkg::opStr:
				decoded.imm = {{(WordWidth - 6){instr[5]}}, instr[5:0]};
			lc3IsaPkg::opBr, lc3IsaPkg::opLd, lc3IsaPkg::opSt,
			lc3IsaPkg::opLdi, lc3IsaPkg::opSti, lc3IsaPkg::opLea:
				decoded.imm = {{(WordWidth - 9){instr[8]}}, instr[8:0]};
			lc3IsaPkg::opJsr:
				decoded.imm = {{(WordWidth - 11){instr[10]}}, instr[10:0]};
			lc3IsaPkg::opTrap:
				decoded.imm = {{(WordWidth - 8){1'b0}}, instr[7:0]};
			default:
				decoded.imm = '0;
		endcase
		// JSRR has bit 11 clear and needs a register, so no target
		if (decoded.opcode == lc3IsaPkg::opBr || (decoded.opcode == lc3IsaPkg::opJsr && instr[11]))
			decoded.target = popEntry.pc + 1'b1 + decoded.imm;
		// Conditional BR never taken, flags live outside this block
		decoded.redirect = (decoded.opcode == lc3IsaPkg::opBr && instr[11:9] == 3'b111)
			|| (decoded.opcode == lc3IsaPkg::opJsr && instr[11]);
	end

	always_ff @(posedge Clk)
	begin
		if (capture)
			outInstr <= decoded;
	end

	always_ff @(posedge Clk)
	begin
		if (reset)
		begin
			outState <= outIdle;
			popAck   <= 1'b0;
			outReq   <= 1'b0;
			redirect <= '0;
		end
		else
		begin
			redirect.valid  <= capture && decoded.redirect;
			redirect.target <= decoded.target;
			if (capture)
				popAck <= 1'b1;
			else if (popAck && !popReq)
				popAck <= 1'b0;
			case (outState)
				outIdle:
					if (capture)
						outState <= outLoaded;
				outLoaded:
				begin
					outReq   <= 1'b1;
					outState <= outOpen;
				end
				outOpen:
				begin
					if (outAck)
					begin
						outReq   <= 1'b0;
						outState <= outClosing;
					end
				end
				outClosing:
					if (!outAck)
						outState <= outIdle;
			endcase
		end
	end

	// Redirect pulses once, on the pop that carried the branch
	redirectPulse: assert property (@(posedge Clk) disable iff (reset)
		redirect.valid |-> $rose(popAck) ##1 !redirect.valid);

endmodule

// File: hw/fetchTop.sv
/* Fetch front end top: fetch unit, instruction queue and decoder */
`timescale 1ns/100ps
`include "lc3_config.svh"

module fetchTop
(
	input  logic                       Clk,
	input  logic                       reset,
	output fetchBusPkg::memReqT        memReq,
	output logic                       memReqValid,
	input  logic                       memAck,
	input  logic [`LC3_WORD_WIDTH-1:0] memData,
	output logic                       outReq,
	output lc3IsaPkg::decodedT         outInstr,
	input  logic                       outAck
);

	logic                    pushReq;
	logic                    pushAck;
	logic                    popReq;
	logic                    popAck;
	fetchBusPkg::queueEntryT pushEntry;
	fetchBusPkg::queueEntryT popEntry;
	fetchBusPkg::redirectT   redirect;

	fetchUnit fetch (.Clk(Clk), .reset(reset),
		.memReq(memReq), .memReqValid(memReqValid), .memAck(memAck), .memData(memData),
		.pushReq(pushReq), .pushEntry(pushEntry), .pushAck(pushAck),
		.redirect(redirect));

	instrQueue queue (.Clk(Clk), .reset(reset),
		.pushReq(pushReq), .pushEntry(pushEntry), .pushAck(pushAck),
		.popReq(popReq), .popEntry(popEntry), .popAck(popAck),
		.redirect(redirect));

	// Decoder drives redirect back to fetch and queue
	instrDecoder decoder (.Clk(Clk), .reset(reset),
		.popReq(popReq), .popEntry(popEntry), .popAck(popAck),
		.redirect(redirect),
		.outReq(outReq), .outInstr(outInstr), .outAck(outAck));

endmodule

// File: dv/tbMemory.sv
/* Behavioral instruction memory: four-phase reads with a random ack delay
   and a fixed program computed from the address */
`timescale 1ns/100ps
`include "lc3_config.svh"

module tbMemory
(
	input  logic                       Clk,
	input  logic                       reset,
	input  fetchBusPkg::memReqT        memReq,
	input  logic                       memReqValid,
	output logic                       memAck,
	output logic [`LC3_WORD_WIDTH-1:0] memData
);

	logic [31:0]                lcgState = 32'h8ddb_d796;
	logic [1:0]                 delay    = 2'd0;
	logic                       ackReg   = 1'b0;
	logic [`LC3_WORD_WIDTH-1:0] dataReg  = '0;

	assign memAck  = ackReg;
	assign memData = dataReg;

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Two unconditional branches, one conditional BR, ADD everywhere else
	function automatic logic [15:0] programWord(input logic [19:0] a);
		logic [4:0] imm5;
		imm5 = a[4:0] ^ a[9:5] ^ a[14:10] ^ a[19:15];
		case (a)
			// BRnzp +6
			20'h03005: return 16'h0E06;
			// BRnz +3
			20'h03008: return 16'h0C03;
			// JSR -12
			20'h03010: return 16'h4FF4;
			default:   return {4'b0001, a[2:0], a[5:3], 1'b1, imm5};
		endcase
	endfunction

	always @(posedge Clk)
	begin
		if (reset)
		begin
			ackReg <= 1'b0;
			delay  <= 2'd0;
		end
		else if (memReqValid && !ackReg)
		begin
			if (delay == 2'd0)
			begin
				ackReg  <= 1'b1;
				dataReg <= programWord(memReq.addr);
			end
			else
				delay <= delay - 2'd1;
		end
		else if (!memReqValid && ackReg)
		begin
			// Next request waits 0 to 3 cycles
			ackReg   <= 1'b0;
			lcgState <= lcgNext(lcgState);
			delay    <= lcgState[17:16];
		end
	end

endmodule

// File: dv/fetchTopTb.sv
/* Testbench for the fetch front end: clock, reset, output acknowledger
   with random delays, expected-PC model and checking assertions */
`timescale 1ns/100ps
`include "lc3_config.svh"

module fetchTopTb;

	localparam int InstrTotal = 60;
	localparam int WaitLimit  = 400;

	logic                       Clk;
	logic                       reset;
	logic                       outAck;
	logic                       memAck;
	logic [`LC3_WORD_WIDTH-1:0] memData;
	logic                       memReqValid;
	logic                       outReq;
	fetchBusPkg::memReqT        memReq;
	lc3IsaPkg::decodedT         outInstr;
	logic [`LC3_WORD_WIDTH-1:0] expPc;
	logic                       outReqPrev;
	logic [31:0]                lcgState;

	fetchTop UUT (.Clk(Clk), .reset(reset),
		.memReq(memReq), .memReqValid(memReqValid), .memAck(memAck), .memData(memData),
		.outReq(outReq), .outInstr(outInstr), .outAck(outAck));

	tbMemory memory (.Clk(Clk), .reset(reset), .memReq(memReq),
		.memReqValid(memReqValid), .memAck(memAck), .memData(memData));

	function automatic logic [31:0] lcgNext(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	// Taken only for BRnzp at 3005 and JSR at 3010
	function automatic logic [15:0] nextPc(input logic [15:0] pc);
		case (pc)
			16'h3005: return 16'h300C;
			16'h3010: return 16'h3005;
			default:  return pc + 16'd1;
		endcase
	endfunction

	function automatic lc3IsaPkg::decodedT expectedInstr(input logic [15:0] pc);
		lc3IsaPkg::decodedT e;
		logic [19:0]        a;
		logic [4:0]         imm5;
		a    = {4'h0, pc};
		imm5 = a[4:0] ^ a[9:5] ^ a[14:10] ^ a[19:15];
		e    = '0;
		e.pc = pc;
		case (pc)
			16'h3005:
			begin
				e.opcode   = lc3IsaPkg::opBr;
				e.dr       = 3'd7;
				e.imm      = 16'd6;
				e.target   = 16'h300C;
				e.redirect = 1'b1;
			end
			16'h3008:
			begin
				// Conditional BR with its target computed but never taken
				e.opcode = lc3IsaPkg::opBr;
				e.dr     = 3'd6;
				e.imm    = 16'd3;
				e.target = 16'h300C;
			end
			16'h3010:
			begin
				e.opcode   = lc3IsaPkg::opJsr;
				e.dr       = 3'd7;
				e.sr1      = 3'd7;
				e.imm      = 16'hFFF4;
				e.target   = 16'h3005;
				e.redirect = 1'b1;
			end
			default:
			begin
				e.opcode = lc3IsaPkg::opAdd;
				e.dr     = pc[2:0];
				e.sr1    = pc[5:3];
				e.imm    = {{11{imm5[4]}}, imm5};
			end
		endcase
		return e;
	endfunction

	task automatic abortRun(input string msg);
		$display("%s", msg);
		$display(">>> FAIL");
		$fatal(1, "Simulation stopped");
	endtask

	task automatic reportValue(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		abortRun($sformatf("** Error at %0t: %s = %h, expected %h", $time, name, got, exp));
	endtask

	task automatic waitOutReq(input logic level);
		int cycles;
		cycles = 0;
		@(posedge Clk);
		while (outReq !== level)
		begin
			if (cycles == WaitLimit)
				abortRun($sformatf("Timeout waiting for outReq to become %0b", level));
			cycles++;
			@(posedge Clk);
		end
	endtask

	initial
	begin
		Clk = 1'b0;
		forever #4 Clk = ~Clk;
	end

	// Expected sequence checked as each output handshake opens
	always @(posedge Clk)
	begin
		if (reset)
		begin
			outReqPrev <= 1'b0;
			expPc      <= `LC3_RESET_PC;
		end
		else
		begin
			outReqPrev <= outReq;
			if (outReq && !outReqPrev)
			begin
				pcOrder: assert (outInstr.pc == expPc)
					else reportValue("outInstr.pc", 64'(outInstr.pc), 64'(expPc));
				fieldsMatch: assert (outInstr == expectedInstr(expPc))
					else reportValue("outInstr", 64'(outInstr), 64'(expectedInstr(expPc)));
				expPc <= nextPc(expPc);
			end
		end
	end

	resetMemQuiet: assert property (@(posedge Clk) $past(reset) |-> !memReqValid)
		else reportValue("memReqValid", 64'd1, 64'd0);

	resetOutQuiet: assert property (@(posedge Clk) $past(reset) |-> !outReq)
		else reportValue("outReq", 64'd1, 64'd0);

	outReqHeld: assert property (@(posedge Clk) disable iff (reset)
		outReq && !outAck |=> outReq)
		else abortRun("outReq fell before outAck rose");

	outInstrStable: assert property (@(posedge Clk) disable iff (reset)
		outReq |=> !outReq || $stable(outInstr))
		else abortRun("outInstr changed while outReq was high");

	initial
	begin
		int i;
		int ackDelay;
		reset    = 1'b1;
		outAck   = 1'b0;
		lcgState = 32'h8ddb_d796;
		repeat (8) @(posedge Clk);
		reset <= 1'b0;
		for (i = 0; i < InstrTotal; i++)
		begin
			waitOutReq(1'b1);
			lcgState = lcgNext(lcgState);
			// Long stalls in the middle third fill the queue
			if (i >= 20 && i < 40)
				ackDelay = int'(lcgState[19:16]);
			else
				ackDelay = int'(lcgState[17:16]);
			repeat (ackDelay) @(posedge Clk);
			outAck <= 1'b1;
			waitOutReq(1'b0);
			if (i == InstrTotal - 1)
				break;
			repeat (ackDelay) @(posedge Clk);
			outAck <= 1'b0;
		end
		$display(">>> PASS");
		$finish;
	end

endmodule

// File: compile.f
+incdir+hw
hw/lc3IsaPkg.sv
hw/fetchBusPkg.sv
hw/fetchUnit.sv
hw/instrQueue.sv
hw/instrDecoder.sv
hw/fetchTop.sv
dv/tbMemory.sv
dv/fetchTopTb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal
TOP       = fetchTopTb
FILELIST  = compile.f
OBJDIR    = obj_dir
BIN       = $(OBJDIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(wildcard hw/*.sv hw/*.svh dv/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJDIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^>>> PASS$$" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
